// ==== rtl/line_code_pkg.sv ====
package line_code_pkg;

	////////////////////
	// Word geometry

	// Bits per 8b/10b codeword
	localparam int WORD_BITS = 10;
	// Enough bits to hold a slip offset of 0 to 9
	localparam int OFFSET_BITS = $clog2(WORD_BITS);

	////////////////////
	// Comma constants

	// Length of the run of equal bits that marks a comma
	localparam int COMMA_RUN = 5;
	// All legal commas put their run at bits 7:3 of an aligned word
	localparam logic [4:0] COMMA_POS = 5'd3;

	// K28 6b sub-blocks, RD- form first (abcdei, a in bit 5)
	localparam logic [5:0] K28_6B_RDN = 6'b001111;
	localparam logic [5:0] K28_6B_RDP = 6'b110000;

	////////////////////
	// Codeword and symbol types

	// Split view of a codeword, abcdei above fghj
	typedef struct packed {
		logic [5:0] sub_6b;
		logic [3:0] sub_4b;
	} codeword_split_t;

	// Comma scan reads the raw word, decode reads the sub-blocks
	typedef union packed {
		logic [9:0] raw;
		codeword_split_t split;
	} codeword_u;

	// Decoded symbol, data is {3b value, 5b value} as in Dx.y
	typedef struct packed {
		logic [7:0] data;
		logic is_ctl;
		logic symbol_err;
		logic disparity_err;
		logic spare;
	} rx_symbol_t;

endpackage

// ==== rtl/rx_link_pkg.sv ====
package rx_link_pkg;

	////////////////////
	// Alignment window

	// Commas per evaluation window, short for simulation
	localparam int COMMA_WINDOW = 16;
	// More bad commas than this in one window forces a slip
	localparam int BAD_LIMIT = 8;
	// Cycles of hits ignored while a slip drains the pipe
	localparam int SLIP_SETTLE = 4;

	localparam int WIN_BITS = $clog2(COMMA_WINDOW);
	localparam int BAD_BITS = $clog2(COMMA_WINDOW + 1);
	localparam int SETTLE_BITS = $clog2(SLIP_SETTLE + 1);

	////////////////////
	// Flow control

	localparam int CREDIT_MAX = 4;
	localparam int QUEUE_DEPTH = 4;
	localparam int CREDIT_BITS = $clog2(CREDIT_MAX + 1);
	localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
	localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

	// Lock state and the one-cycle slip request
	typedef struct packed {
		logic locked;
		logic bitslip;
	} align_status_t;

endpackage

// ==== rtl/word_slipper.sv ====
`timescale 1ns/1ns

module word_slipper import line_code_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic raw_valid,
	input  logic [9:0] raw_word,
	input  logic bitslip,
	output logic aligned_valid,
	output codeword_u aligned,
	output logic [19:0] window
);

	// Last raw word from the deserializer
	logic [WORD_BITS-1:0] prev_raw;
	// Current word boundary, 0 to 9 bits into the previous word
	logic [OFFSET_BITS-1:0] offset;
	logic [2*WORD_BITS-1:0] joined;
	codeword_u next_word;

	assign joined = {prev_raw, raw_word};
	assign next_word.raw = joined[offset +: WORD_BITS];

	// Offset moves one bit per slip request, wraps after 9
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			offset <= '0;
			aligned_valid <= 1'b0;
		end else begin
			aligned_valid <= raw_valid;
			if (bitslip)
				offset <= (offset == OFFSET_BITS'(WORD_BITS - 1)) ? '0 : offset + 1'b1;
		end
	end

	// Window is the last aligned word above the new one
	always_ff @(posedge clk) begin
		if (raw_valid) begin
			prev_raw <= raw_word;
			aligned <= next_word;
			window <= {aligned.raw, next_word.raw};
		end
	end

	a_offset_range: assert property (@(posedge clk) disable iff (!rst_n)
		offset < OFFSET_BITS'(WORD_BITS));

endmodule

// ==== rtl/comma_detector.sv ====
`timescale 1ns/1ns

module comma_detector import line_code_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic aligned_valid,
	input  logic [19:0] window,
	output logic comma_hit,
	output logic [4:0] comma_pos
);

	logic hit_c;
	logic [4:0] pos_c;

	// Check each five-bit slice starting in the newer word
	// Later slices win, so the highest position is reported
	always_comb begin
		hit_c = 1'b0;
		pos_c = '0;
		for (int i = 0; i < WORD_BITS; i++) begin
			// Positive or negative comma run
			if (window[i +: COMMA_RUN] == {COMMA_RUN{1'b1}} || window[i +: COMMA_RUN] == '0) begin
				hit_c = 1'b1;
				pos_c = 5'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			comma_hit <= 1'b0;
		else
			comma_hit <= aligned_valid && hit_c;
	end

	// Position only means something alongside a hit
	always_ff @(posedge clk) begin
		if (aligned_valid && hit_c)
			comma_pos <= pos_c;
	end

endmodule

// ==== rtl/alignment_monitor.sv ====
`timescale 1ns/1ns

module alignment_monitor import line_code_pkg::*, rx_link_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic comma_hit,
	input  logic [4:0] comma_pos,
	output align_status_t status
);

	logic [WIN_BITS-1:0] comma_count;
	logic [BAD_BITS-1:0] bad_count;
	logic [BAD_BITS-1:0] bad_next;
	// Counts down after a slip, hits from the old offset are dropped
	logic [SETTLE_BITS-1:0] settle;
	logic hit_ok;

	assign hit_ok = comma_hit && (settle == '0);
	// Bad count including the comma seen this cycle
	assign bad_next = bad_count + BAD_BITS'(comma_pos != COMMA_POS);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			comma_count <= '0;
			bad_count <= '0;
			settle <= '0;
			status <= '0;
		end else begin
			status.bitslip <= 1'b0;
			if (settle != '0)
				settle <= settle - 1'b1;

			if (hit_ok) begin
				// Window counter wraps by itself at COMMA_WINDOW
				comma_count <= comma_count + 1'b1;
				bad_count <= bad_next;

				////////////////////
				// End of window

				if (comma_count == WIN_BITS'(COMMA_WINDOW - 1)) begin
					bad_count <= '0;
					if (bad_next > BAD_BITS'(BAD_LIMIT)) begin
						// Mostly misplaced, shift the boundary
						status.locked <= 1'b0;
						status.bitslip <= 1'b1;
						settle <= SETTLE_BITS'(SLIP_SETTLE);
					end else if (bad_next == '0) begin
						status.locked <= 1'b1;
					end
				end
			end
		end
	end

	a_no_slip_while_locked: assert property (@(posedge clk) disable iff (!rst_n)
		!(status.locked && status.bitslip));

endmodule

// ==== rtl/symbol_decoder.sv ====
`timescale 1ns/1ns

module symbol_decoder import line_code_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic aligned_valid,
	input  codeword_u aligned,
	output logic dec_valid,
	output rx_symbol_t dec_sym
);

	logic [5:0] code6;
	logic [3:0] code4;
	logic [4:0] val5;
	logic [2:0] val3;
	logic ctl;
	logic k28_rdn;
	logic err6;
	logic err4;
	// Sub-block and total disparity, signed
	int disp6;
	int disp4;
	int disp_total;
	logic flip_pos;
	logic flip_neg;
	// Running disparity, set while negative
	logic rd_neg;
	rx_symbol_t sym_c;

	assign code6 = aligned.split.sub_6b;
	assign code4 = aligned.split.sub_4b;
	assign ctl = (code6 == K28_6B_RDN) || (code6 == K28_6B_RDP);
	assign k28_rdn = code6 == K28_6B_RDN;

	////////////////////
	// 6b to 5b

	always_comb begin
		err6 = 1'b0;
		val5 = 5'd0;
		case (code6)
			6'b100111, 6'b011000: val5 = 5'd0;
			6'b011101, 6'b100010: val5 = 5'd1;
			6'b101101, 6'b010010: val5 = 5'd2;
			6'b110001: val5 = 5'd3;
			6'b110101, 6'b001010: val5 = 5'd4;
			6'b101001: val5 = 5'd5;
			6'b011001: val5 = 5'd6;
			6'b111000, 6'b000111: val5 = 5'd7;
			6'b111001, 6'b000110: val5 = 5'd8;
			6'b100101: val5 = 5'd9;
			6'b010101: val5 = 5'd10;
			6'b110100: val5 = 5'd11;
			6'b001101: val5 = 5'd12;
			6'b101100: val5 = 5'd13;
			6'b011100: val5 = 5'd14;
			6'b010111, 6'b101000: val5 = 5'd15;
			6'b011011, 6'b100100: val5 = 5'd16;
			6'b100011: val5 = 5'd17;
			6'b010011: val5 = 5'd18;
			6'b110010: val5 = 5'd19;
			6'b001011: val5 = 5'd20;
			6'b101010: val5 = 5'd21;
			6'b011010: val5 = 5'd22;
			6'b111010, 6'b000101: val5 = 5'd23;
			6'b110011, 6'b001100: val5 = 5'd24;
			6'b100110: val5 = 5'd25;
			6'b010110: val5 = 5'd26;
			6'b110110, 6'b001001: val5 = 5'd27;
			6'b001110: val5 = 5'd28;
			6'b101110, 6'b010001: val5 = 5'd29;
			6'b011110, 6'b100001: val5 = 5'd30;
			6'b101011, 6'b010100: val5 = 5'd31;
			K28_6B_RDN, K28_6B_RDP: val5 = 5'd28;
			default: err6 = 1'b1;
		endcase
	end

	////////////////////
	// 4b to 3b

	// K28.1, .2, .5, .6 share balanced codes, the 6b half picks which
	always_comb begin
		err4 = 1'b0;
		val3 = 3'd0;
		if (ctl) begin
			case (code4)
				4'b0100, 4'b1011: val3 = 3'd0;
				4'b1001: val3 = k28_rdn ? 3'd1 : 3'd6;
				4'b0101: val3 = k28_rdn ? 3'd2 : 3'd5;
				4'b0011, 4'b1100: val3 = 3'd3;
				4'b0010, 4'b1101: val3 = 3'd4;
				4'b1010: val3 = k28_rdn ? 3'd5 : 3'd2;
				4'b0110: val3 = k28_rdn ? 3'd6 : 3'd1;
				4'b1000, 4'b0111: val3 = 3'd7;
				default: err4 = 1'b1;
			endcase
		end else begin
			case (code4)
				4'b1011, 4'b0100: val3 = 3'd0;
				4'b1001: val3 = 3'd1;
				4'b0101: val3 = 3'd2;
				4'b1100, 4'b0011: val3 = 3'd3;
				4'b1101, 4'b0010: val3 = 3'd4;
				4'b1010: val3 = 3'd5;
				4'b0110: val3 = 3'd6;
				// Primary and alternate D.x.7
				4'b1110, 4'b0001, 4'b0111, 4'b1000: val3 = 3'd7;
				default: err4 = 1'b1;
			endcase
		end
	end

	////////////////////
	// Merge and disparity

	always_comb begin
		// Disparity is twice the ones count minus the width
		disp6 = err6 ? 0 : 2 * $countones(code6) - 6;
		disp4 = err4 ? 0 : 2 * $countones(code4) - 4;
		disp_total = disp6 + disp4;
		flip_pos = rd_neg && (disp_total == 2);
		flip_neg = !rd_neg && (disp_total == -2);
		sym_c.data = {val3, val5};
		sym_c.is_ctl = ctl;
		sym_c.symbol_err = err6 || err4;
		sym_c.disparity_err = (disp_total != 0) && !flip_pos && !flip_neg;
		sym_c.spare = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			rd_neg <= 1'b1;
		end else begin
			dec_valid <= aligned_valid;
			// Bad disparity leaves RD where it was
			if (aligned_valid && flip_pos)
				rd_neg <= 1'b0;
			else if (aligned_valid && flip_neg)
				rd_neg <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (aligned_valid)
			dec_sym <= sym_c;
	end

endmodule

// ==== rtl/credit_queue.sv ====
`timescale 1ns/1ns

module credit_queue import line_code_pkg::*, rx_link_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic dec_valid,
	input  rx_symbol_t dec_sym,
	input  logic locked,
	input  logic credit_return,
	output logic sym_valid,
	output rx_symbol_t sym,
	output logic overflow
);

	rx_symbol_t mem [QUEUE_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [COUNT_BITS-1:0] count;
	logic [CREDIT_BITS-1:0] credits;
	logic [CREDIT_BITS-1:0] credits_left;
	logic push, have_data, send, pop_mem, bypass, store, drop, accept;

	// Nothing enters before the link is aligned
	assign push = dec_valid && locked;
	assign have_data = count != '0;
	assign send = (credits != '0) && (have_data || push);
	assign pop_mem = send && have_data;
	// Empty queue, new symbol goes straight out
	assign bypass = send && !have_data;
	assign store = push && !bypass;
	// Full unless a slot frees this cycle
	assign drop = store && (count == COUNT_BITS'(QUEUE_DEPTH)) && !pop_mem;
	assign accept = store && !drop;
	assign credits_left = credits - CREDIT_BITS'(send);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= CREDIT_BITS'(CREDIT_MAX);
			sym_valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			sym_valid <= send;
			if (accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_mem)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + COUNT_BITS'(accept) - COUNT_BITS'(pop_mem);
			// Returned credit saturates at the reset value
			if (credit_return && credits_left != CREDIT_BITS'(CREDIT_MAX))
				credits <= credits_left + 1'b1;
			else
				credits <= credits_left;
			// Sticky until reset
			if (drop)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			mem[wr_ptr] <= dec_sym;
		if (pop_mem)
			sym <= mem[rd_ptr];
		else if (bypass)
			sym <= dec_sym;
	end

	a_send_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
		sym_valid |-> $past(credits) != '0);

endmodule

// ==== rtl/link_rx_top.sv ====
`timescale 1ns/1ns

module link_rx_top import line_code_pkg::*, rx_link_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic raw_valid,
	input  logic [9:0] raw_word,
	input  logic credit_return,
	output logic sym_valid,
	output rx_symbol_t sym,
	output align_status_t status,
	output logic overflow
);

	////////////////////
	// Internal links

	logic aligned_valid;
	codeword_u aligned;
	logic [19:0] window;
	logic comma_hit;
	logic [4:0] comma_pos;
	logic dec_valid;
	rx_symbol_t dec_sym;

	// Boundary select, slips on monitor request
	word_slipper u_slipper (
		.clk(clk), .rst_n(rst_n),
		.raw_valid(raw_valid), .raw_word(raw_word), .bitslip(status.bitslip),
		.aligned_valid(aligned_valid), .aligned(aligned), .window(window)
	);

	comma_detector u_detector (
		.clk(clk), .rst_n(rst_n),
		.aligned_valid(aligned_valid), .window(window),
		.comma_hit(comma_hit), .comma_pos(comma_pos)
	);

	alignment_monitor u_monitor (
		.clk(clk), .rst_n(rst_n),
		.comma_hit(comma_hit), .comma_pos(comma_pos), .status(status)
	);

	symbol_decoder u_decoder (
		.clk(clk), .rst_n(rst_n),
		.aligned_valid(aligned_valid), .aligned(aligned),
		.dec_valid(dec_valid), .dec_sym(dec_sym)
	);

	// Output side, gated by lock
	credit_queue u_queue (
		.clk(clk), .rst_n(rst_n),
		.dec_valid(dec_valid), .dec_sym(dec_sym), .locked(status.locked),
		.credit_return(credit_return),
		.sym_valid(sym_valid), .sym(sym), .overflow(overflow)
	);

endmodule

// ==== tests/tb_link_rx.sv ====
`timescale 1ns/1ns

module tb_link_rx import line_code_pkg::*, rx_link_pkg::*;;

	// K28.5 in both disparities with abcdei above fghj
	localparam logic [9:0] K285_RDP = 10'h305;
	localparam logic [9:0] K285_RDN = 10'h0FA;
	localparam int NUM_ROWS = 18;
	// Words allowed for ten windows and their settle gaps
	localparam int ROT_WORDS = 10 * (COMMA_WINDOW + SLIP_SETTLE) + 8;
	localparam int TOTAL_WORDS = 9 * ROT_WORDS + COMMA_WINDOW + NUM_ROWS * 5;
	localparam int WATCH_NS = (TOTAL_WORDS + 1500) * 8;

	// One table row with its expected decode
	typedef struct packed {
		logic [9:0] code;
		logic [7:0] value;
		logic ctl;
		logic sym_err;
		logic disp_err;
		logic data_ok;
	} row_t;

	logic clk;
	logic rst_n;
	logic raw_valid;
	logic [9:0] raw_word;
	logic credit_return;
	logic sym_valid;
	rx_symbol_t sym;
	align_status_t status;
	logic overflow;

	row_t rows [NUM_ROWS];
	int exp_q [$];
	int errors;
	int sent_count;
	int slip_count;
	int rot;
	int out_idx;
	int base;
	logic [9:0] prev_word;
	logic [31:0] lfsr;
	logic credit_en;
	logic compare_on;
	logic locked_seen;

	link_rx_top DUT (
		.clk(clk), .rst_n(rst_n),
		.raw_valid(raw_valid), .raw_word(raw_word), .credit_return(credit_return),
		.sym_valid(sym_valid), .sym(sym), .status(status), .overflow(overflow)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////
	// Helpers

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic reset_dut();
		@(posedge clk);
		rst_n <= 1'b0;
		raw_valid <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
	endtask

	// Bit shifter that delays the stream by rot bits across word edges
	task automatic send_word(input logic [9:0] w);
		logic [19:0] joined;
		joined = {prev_word, w};
		prev_word = w;
		@(posedge clk);
		raw_valid <= 1'b1;
		raw_word <= 10'(joined >> rot);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			raw_valid <= 1'b0;
		end
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Error at %0t: %0d expected symbols never came out", $time, exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	////////////////////
	// Background processes

	// One LFSR bit per cycle sets credit_return while enabled
	initial begin
		forever begin
			@(posedge clk);
			if (credit_en) begin
				lfsr = lfsr_step(lfsr);
				credit_return <= lfsr[0];
			end else begin
				credit_return <= 1'b0;
			end
		end
	end

	// Outputs are read mid cycle away from the driving edge
	initial begin
		forever begin
			@(negedge clk);
			if (status.bitslip)
				slip_count++;
			if (sym_valid) begin
				sent_count++;
				if (!status.locked) begin
					$display("Error at %0t: symbol sent while the link is not locked", $time);
					errors++;
				end else if (compare_on) begin
					if (exp_q.size() == 0) begin
						$display("Error at %0t: symbol sent with none expected", $time);
						errors++;
					end else begin
						out_idx = exp_q.pop_front();
						if (rows[out_idx].data_ok)
							compare_value("sym.data", rows[out_idx].value, sym.data);
						compare_value("sym.is_ctl", rows[out_idx].ctl, sym.is_ctl);
						compare_value("sym.symbol_err", rows[out_idx].sym_err, sym.symbol_err);
						compare_value("sym.disparity_err", rows[out_idx].disp_err,
							sym.disparity_err);
						compare_value("sym.spare", 1'b0, sym.spare);
					end
				end
			end
		end
	end

	initial begin
		#(WATCH_NS);
		$display("Timeout: the run did not finish in %0d ns", WATCH_NS);
		$display("Test failures found");
		$finish;
	end

	////////////////////
	// Main sequence

	initial begin
		rst_n = 1'b0;
		raw_valid = 1'b0;
		raw_word = '0;
		credit_return = 1'b0;
		credit_en = 1'b0;
		compare_on = 1'b0;
		lfsr = 32'h347f;
		errors = 0;
		sent_count = 0;
		slip_count = 0;
		rot = 0;

		// Table starts and ends in positive RD
		rows[0] = '{10'h305, 8'hBC, 1'b1, 1'b0, 1'b0, 1'b1};
		rows[1] = '{10'h0FA, 8'hBC, 1'b1, 1'b0, 1'b0, 1'b1};
		rows[2] = '{10'h2AA, 8'hB5, 1'b0, 1'b0, 1'b0, 1'b1};
		rows[3] = '{10'h18B, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1};
		rows[4] = '{10'h313, 8'h63, 1'b0, 1'b0, 1'b0, 1'b1};
		rows[5] = '{10'h05D, 8'h97, 1'b0, 1'b0, 1'b0, 1'b1};
		// RD+ forms of K28.0 and K28.3
		rows[6] = '{10'h30B, 8'h1C, 1'b1, 1'b0, 1'b0, 1'b1};
		rows[7] = '{10'h30C, 8'h7C, 1'b1, 1'b0, 1'b0, 1'b1};
		rows[8] = '{10'h272, 8'h80, 1'b0, 1'b0, 1'b0, 1'b1};
		rows[9] = '{10'h0F5, 8'h5C, 1'b1, 1'b0, 1'b0, 1'b1};
		// Invalid 6b half
		rows[10] = '{10'h03A, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0};
		rows[11] = '{10'h314, 8'h03, 1'b0, 1'b0, 1'b0, 1'b1};
		rows[12] = '{10'h31B, 8'h03, 1'b0, 1'b0, 1'b0, 1'b1};
		// Same +2 word again while RD is already positive
		rows[13] = '{10'h31B, 8'h03, 1'b0, 1'b0, 1'b1, 1'b1};
		rows[14] = '{10'h155, 8'h4A, 1'b0, 1'b0, 1'b0, 1'b1};
		rows[15] = '{10'h305, 8'hBC, 1'b1, 1'b0, 1'b0, 1'b1};
		rows[16] = '{10'h0E9, 8'h3C, 1'b0, 1'b0, 1'b0, 1'b1};
		rows[17] = '{10'h0FA, 8'hBC, 1'b1, 1'b0, 1'b0, 1'b1};

		// Rotated comma streams must slip until aligned
		for (int n = 1; n < 10; n++) begin
			reset_dut();
			rot = n;
			prev_word = K285_RDN;
			slip_count = 0;
			locked_seen = 1'b0;
			for (int i = 0; i < ROT_WORDS && !locked_seen; i++) begin
				send_word((i % 2 == 0) ? K285_RDP : K285_RDN);
				@(negedge clk);
				locked_seen = status.locked;
			end
			idle(2);
			if (!locked_seen) begin
				$display("Error: stream rotated by %0d bits did not lock within ten windows", n);
				errors++;
			end else begin
				compare_value("bitslip pulses", 10 - n, slip_count);
			end
		end

		// Aligned stream of one window of commas
		reset_dut();
		rot = 0;
		prev_word = K285_RDN;
		slip_count = 0;
		for (int i = 0; i < COMMA_WINDOW; i++)
			send_word((i % 2 == 0) ? K285_RDP : K285_RDN);
		idle(4);
		@(negedge clk);
		compare_value("status.locked", 1, status.locked);
		compare_value("bitslip pulses", 0, slip_count);

		// Without credit returns four go out and four are stored and the rest are dropped
		compare_on = 1'b1;
		base = sent_count;
		for (int r = 0; r < NUM_ROWS; r++) begin
			send_word(rows[r].code);
			if (r < CREDIT_MAX + QUEUE_DEPTH)
				exp_q.push_back(r);
		end
		idle(8);
		@(negedge clk);
		compare_value("symbols without credit", CREDIT_MAX, sent_count - base);
		compare_value("overflow", 1, overflow);
		credit_en = 1'b1;
		wait_drain(300);

		// Spaced rows with random credit returns must all arrive
		for (int r = 0; r < NUM_ROWS; r++) begin
			send_word(rows[r].code);
			exp_q.push_back(r);
			idle(3);
		end
		wait_drain(400);
		idle(4);

		$display("Checks done, errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== list.f ====
rtl/line_code_pkg.sv
rtl/rx_link_pkg.sv
rtl/word_slipper.sv
rtl/comma_detector.sv
rtl/alignment_monitor.sv
rtl/symbol_decoder.sv
rtl/credit_queue.sv
rtl/link_rx_top.sv
tests/tb_link_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the link receive testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_link_rx \
	-f list.f -o sim_link_rx &&
out=$(./obj_dir/sim_link_rx) ;
echo "$out" ;
echo "$out" | grep -q "All tests passed!" && echo "PASS" || { echo "FAIL"; exit 1; }
